// ==== verilog.f ====
source/blimp_pkg.sv
source/blimp_stage_if.sv
source/blimp_fetch.sv
source/blimp_decode.sv
source/blimp_execute.sv
source/blimp_result.sv
source/blimp_core.sv
test/blimp_checker.sv
test/blimp_tb.sv

// ==== Bender.yml ====
package:
  name: blimp

sources:
  # Core RTL, package first
  - source/blimp_pkg.sv
  - source/blimp_stage_if.sv
  - source/blimp_fetch.sv
  - source/blimp_decode.sv
  - source/blimp_execute.sv
  - source/blimp_result.sv
  - source/blimp_core.sv

  # Testbench
  - target: test
    files:
      - test/blimp_checker.sv
      - test/blimp_tb.sv

// ==== test/blimp_tb.sv ====
/*
 * Testbench for the blimp core. Plays the instruction memory with random
 * delays and runs directed and random programs; blimp_checker compares the trace.
 */
module blimp_tb import blimp_pkg::*; ();

  localparam logic [xlen-1:0] park_word = {25'b0, opc_jal};
  localparam int              run_limit = 2000;

  logic                  clk;
  logic                  rst_n;
  logic                  imem_req_val;
  logic [xlen-1:0]       imem_req_addr;
  logic                  imem_req_rdy;
  logic                  imem_resp_val;
  logic [xlen-1:0]       imem_resp_data;
  logic                  trace_val;
  logic [xlen-1:0]       trace_pc;
  logic [reg_addr_w-1:0] trace_waddr;
  logic [xlen-1:0]       trace_wdata;
  logic                  trace_wen;

  logic [xlen-1:0] prog [64];
  int              prog_len;
  bit              delays_on;
  integer          seed;
  int              errors;
  int              retired;
  int              timeouts;
  // Responder state
  bit              pending;
  logic [xlen-1:0] resp_word;
  int              resp_delay;
  int              rdy_wait;

  blimp_core #(.p_reset_pc(32'h0)) uut (
    .clk(clk), .rst_n(rst_n),
    .imem_req_val(imem_req_val), .imem_req_addr(imem_req_addr),
    .imem_req_rdy(imem_req_rdy), .imem_resp_val(imem_resp_val),
    .imem_resp_data(imem_resp_data), .trace_val(trace_val), .trace_pc(trace_pc),
    .trace_waddr(trace_waddr), .trace_wdata(trace_wdata), .trace_wen(trace_wen)
  );

  blimp_checker u_check (
    .clk(clk), .rst_n(rst_n), .prog(prog), .prog_len(prog_len),
    .trace_val(trace_val), .trace_pc(trace_pc), .trace_waddr(trace_waddr),
    .trace_wdata(trace_wdata), .trace_wen(trace_wen),
    .errors(errors), .retired(retired)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Instruction encoders
  // ----------------------------------------------------------------------

  function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
  endfunction

  function automatic logic [31:0] alu_ri(input logic [2:0] f3, input int rd,
                                         input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc_op_imm};
  endfunction

  function automatic logic [31:0] lui_word(input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc_lui};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                              input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] jal_word(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
  endfunction

  function automatic logic [xlen-1:0] program_word(input logic [xlen-1:0] addr);
    if (addr[xlen-1:2] < prog_len)
      return prog[addr[7:2]];
    return park_word;
  endfunction

  function automatic int pick_delay();
    return delays_on ? $unsigned($random(seed)) % 4 : 0;
  endfunction

  // ----------------------------------------------------------------------
  // Instruction-memory responder
  // ----------------------------------------------------------------------

  initial begin
    imem_req_rdy   = 1'b0;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    pending        = 1'b0;
    resp_delay     = 0;
    rdy_wait       = 0;
    forever begin
      // Look at what the coming edge will accept
      @(negedge clk);
      if (!rst_n) begin
        pending  = 1'b0;
        rdy_wait = 0;
      end else if (imem_req_val && imem_req_rdy) begin
        pending    = 1'b1;
        resp_word  = program_word(imem_req_addr);
        resp_delay = pick_delay();
        rdy_wait   = pick_delay();
      end else if (imem_req_val && rdy_wait > 0) begin
        rdy_wait--;
      end
      @(posedge clk);
      #2;
      imem_resp_val = 1'b0;
      if (pending && resp_delay == 0) begin
        imem_resp_val  = 1'b1;
        imem_resp_data = resp_word;
        pending        = 1'b0;
      end else if (pending) begin
        resp_delay--;
      end
      imem_req_rdy = (rdy_wait == 0);
    end
  end

  // ----------------------------------------------------------------------
  // Run control
  // ----------------------------------------------------------------------

  task automatic hold_reset();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
  endtask

  task automatic add_word(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // Release reset, then wait for the core to park past the program
  task automatic run_program(input string name, input bit with_delays);
    int          cycles;
    bit          parked;
    logic [31:0] park_pc;
    park_pc           = prog_len * 4;
    u_check.test_name = name;
    delays_on         = with_delays;
    repeat (3) @(posedge clk);
    #2;
    rst_n  = 1'b1;
    cycles = 0;
    parked = 1'b0;
    while (!parked && cycles < run_limit) begin
      @(negedge clk);
      cycles++;
      parked = trace_val && (trace_pc >= park_pc);
    end
    if (!parked) begin
      timeouts++;
      $display("Timeout: %s never reached the self-loop at %h", name, park_pc);
    end
  endtask

  // Prologue sets x1..x7, then ALU-heavy mix with forward branches only
  task automatic build_random_program();
    int kind;
    int rd;
    int rs1;
    int rs2;
    prog_len = 0;
    for (int r = 1; r < 8; r++)
      add_word(alu_ri(f3_add_sub, r, 0, $random(seed)));
    while (prog_len < 60) begin
      kind = $unsigned($random(seed)) % 10;
      rd   = $unsigned($random(seed)) % 8;
      rs1  = $unsigned($random(seed)) % 8;
      rs2  = $unsigned($random(seed)) % 8;
      case (kind)
        0: add_word(alu_rr(f7_base, f3_add_sub, rd, rs1, rs2));
        1: add_word(alu_rr(f7_sub, f3_add_sub, rd, rs1, rs2));
        2: add_word(alu_rr(f7_base, f3_and, rd, rs1, rs2));
        3: add_word(alu_rr(f7_base, f3_or, rd, rs1, rs2));
        4: add_word(alu_rr(f7_base, f3_xor, rd, rs1, rs2));
        5: add_word(alu_rr(f7_base, f3_slt, rd, rs1, rs2));
        6: add_word(alu_ri(f3_add_sub, rd, rs1, $random(seed)));
        7: add_word(alu_ri(f3_xor, rd, rs1, $random(seed)));
        8: add_word(lui_word(rd, $random(seed)));
        default: add_word(branch_word(rd[0] ? f3_bne : f3_beq, rs1, rs2, 8));
      endcase
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    seed      = 32'h323c_fd14;
    delays_on = 1'b0;
    prog_len  = 0;
    timeouts  = 0;

    // Register-register ALU
    hold_reset();
    prog_len = 0;
    add_word(alu_ri(f3_add_sub, 1, 0, 25));
    add_word(alu_ri(f3_add_sub, 2, 0, -7));
    add_word(alu_ri(f3_add_sub, 3, 0, 100));
    add_word(alu_rr(f7_base, f3_add_sub, 4, 1, 2));
    add_word(alu_rr(f7_sub, f3_add_sub, 5, 1, 3));
    add_word(alu_rr(f7_base, f3_and, 6, 1, 3));
    add_word(alu_rr(f7_base, f3_or, 7, 1, 2));
    add_word(alu_rr(f7_base, f3_xor, 8, 1, 3));
    add_word(alu_rr(f7_base, f3_slt, 9, 2, 1));
    add_word(alu_rr(f7_base, f3_slt, 10, 1, 2));
    run_program("alu_rr", 1'b0);

    // Sign-extended immediates and LUI, register values carry over
    hold_reset();
    prog_len = 0;
    add_word(alu_ri(f3_add_sub, 11, 0, -2048));
    add_word(alu_ri(f3_and, 12, 3, -16));
    add_word(alu_ri(f3_or, 13, 1, -256));
    add_word(alu_ri(f3_xor, 14, 3, -1));
    add_word(lui_word(15, 20'habcde));
    add_word(alu_ri(f3_add_sub, 15, 15, 12'h123));
    add_word(lui_word(16, 20'h80000));
    run_program("imm_lui", 1'b0);

    // Writes to x0 and illegal words
    hold_reset();
    prog_len = 0;
    add_word(alu_rr(f7_base, f3_add_sub, 0, 1, 2));
    add_word(32'h0000_0000);
    add_word(alu_ri(f3_or, 0, 1, 7));
    add_word(32'hffff_ffff);
    add_word(alu_ri(f3_add_sub, 17, 0, 1));
    run_program("x0_illegal", 1'b0);

    // Taken and not-taken branches, forward JAL with link
    hold_reset();
    prog_len = 0;
    add_word(alu_ri(f3_add_sub, 18, 0, 5));
    add_word(alu_ri(f3_add_sub, 19, 0, 5));
    add_word(branch_word(f3_beq, 18, 19, 8));
    add_word(alu_ri(f3_add_sub, 20, 0, 1));
    add_word(branch_word(f3_beq, 18, 0, 8));
    add_word(branch_word(f3_bne, 18, 0, 8));
    add_word(alu_ri(f3_add_sub, 20, 0, 2));
    add_word(branch_word(f3_bne, 18, 19, 8));
    add_word(jal_word(21, 12));
    add_word(alu_ri(f3_add_sub, 20, 0, 3));
    add_word(alu_ri(f3_add_sub, 20, 0, 4));
    add_word(alu_ri(f3_add_sub, 22, 0, 9));
    run_program("branch_jal", 1'b0);

    // Same random program, first without and then with memory delays
    hold_reset();
    build_random_program();
    run_program("random_nodelay", 1'b0);
    hold_reset();
    run_program("random_delay", 1'b1);

    $display("Summary: errors %0d timeouts %0d retired %0d", errors, timeouts, retired);
    if (errors == 0 && timeouts == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== test/blimp_checker.sv ====
/*
 * Trace checker for the blimp core testbench.
 * Runs its own instruction-set model over the program and compares each retirement.
 */
module blimp_checker import blimp_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [xlen-1:0]       prog [64],
  input  int                    prog_len,
  input  logic                  trace_val,
  input  logic [xlen-1:0]       trace_pc,
  input  logic [reg_addr_w-1:0] trace_waddr,
  input  logic [xlen-1:0]       trace_wdata,
  input  logic                  trace_wen,
  output int                    errors,
  output int                    retired
);

  // Expected retirement of one instruction
  typedef struct packed {
    logic                  wen;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
    logic [xlen-1:0]       next_pc;
  } ret_rec_t;

  // JAL x0, 0 past the end of the program
  localparam logic [xlen-1:0] park_word = {25'b0, opc_jal};

  string           test_name;
  logic [xlen-1:0] regs [32];
  logic [xlen-1:0] pc;
  logic [xlen-1:0] inst;
  ret_rec_t        want;

  initial begin
    test_name = "none";
    errors    = 0;
    retired   = 0;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
  end

  function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr);
    if (addr[xlen-1:2] < prog_len)
      return prog[addr[7:2]];
    return park_word;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b, inout logic writes);
    case (f3)
      f3_add_sub: return a + b;
      f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_xor:     return a ^ b;
      f3_or:      return a | b;
      f3_and:     return a & b;
      default: begin
        writes = 1'b0;
        return '0;
      end
    endcase
  endfunction

  function automatic ret_rec_t model_step(input logic [xlen-1:0] word,
                                          input logic [xlen-1:0] at_pc);
    ret_rec_t        r;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [2:0]      f3;
    logic            writes;
    a      = regs[word[19:15]];
    b      = regs[word[24:20]];
    f3     = word[14:12];
    imm_i  = {{20{word[31]}}, word[31:20]};
    imm_b  = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_j  = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    writes = 1'b1;
    r.waddr   = word[11:7];
    r.wdata   = '0;
    r.next_pc = at_pc + 32'd4;
    case (word[6:0])
      opc_op: begin
        if (word[31:25] == f7_sub && f3 == f3_add_sub)
          r.wdata = a - b;
        else if (word[31:25] == f7_base)
          r.wdata = alu_ref(f3, a, b, writes);
        else
          writes = 1'b0;
      end
      // No SLTI in this subset
      opc_op_imm: begin
        if (f3 == f3_slt)
          writes = 1'b0;
        else
          r.wdata = alu_ref(f3, a, imm_i, writes);
      end
      opc_lui:
        r.wdata = {word[31:12], 12'b0};
      opc_branch: begin
        writes = 1'b0;
        if ((f3 == f3_beq && a == b) || (f3 == f3_bne && a != b))
          r.next_pc = at_pc + imm_b;
      end
      opc_jal: begin
        r.wdata   = at_pc + 32'd4;
        r.next_pc = at_pc + imm_j;
      end
      default:
        writes = 1'b0;
    endcase
    r.wen = writes && (word[11:7] != 5'd0);
    return r;
  endfunction

  task automatic compare_field(input string field, input logic [xlen-1:0] exp_val,
                               input logic [xlen-1:0] act_val);
    if (exp_val !== act_val) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h actual %h",
               test_name, field, exp_val, act_val);
    end
  endtask

  // ----------------------------------------------------------------------
  // Comparison on each retirement, sampled mid-cycle
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    if (!rst_n) begin
      pc = '0;
    end else if (trace_val) begin
      inst = word_at(pc);
      want = model_step(inst, pc);
      compare_field("pc", pc, trace_pc);
      compare_field("waddr", want.waddr, trace_waddr);
      compare_field("wen", want.wen, trace_wen);
      // Data only matters when something is written
      if (want.wen) begin
        compare_field("wdata", want.wdata, trace_wdata);
        regs[want.waddr] = want.wdata;
      end
      pc = want.next_pc;
      retired++;
    end
  end

endmodule

// ==== source/blimp_core.sv ====
/*
 * Top level of the blimp core with plain memory and trace ports.
 * Wires fetch, decode, execute and result; one instruction in flight.
 */
module blimp_core import blimp_pkg::*; #(
  parameter logic [xlen-1:0] p_reset_pc = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Instruction memory
  output logic                  imem_req_val,
  output logic [xlen-1:0]       imem_req_addr,
  input  logic                  imem_req_rdy,
  input  logic                  imem_resp_val,
  input  logic [xlen-1:0]       imem_resp_data,
  // Retirement trace
  output logic                  trace_val,
  output logic [xlen-1:0]       trace_pc,
  output logic [reg_addr_w-1:0] trace_waddr,
  output logic [xlen-1:0]       trace_wdata,
  output logic                  trace_wen
);

  // Fetch to decode
  logic                  fd_val;
  logic [xlen-1:0]       fd_pc;
  logic [xlen-1:0]       fd_inst;
  // Result to decode
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0]       wb_data;
  // Result to fetch
  logic                  redirect_val;
  logic [xlen-1:0]       redirect_pc;

  blimp_dx_if dx_if ();
  blimp_xr_if xr_if ();

  // ----------------------------------------------------------------------
  // Stages
  // ----------------------------------------------------------------------

  blimp_fetch #(
    .p_reset_pc (p_reset_pc)
  ) u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_req_rdy   (imem_req_rdy),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .fd_val         (fd_val),
    .fd_pc          (fd_pc),
    .fd_inst        (fd_inst),
    .redirect_val   (redirect_val),
    .redirect_pc    (redirect_pc)
  );

  blimp_decode u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .fd_val  (fd_val),
    .fd_pc   (fd_pc),
    .fd_inst (fd_inst),
    .dx      (dx_if.src),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  blimp_execute u_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .dx    (dx_if.dst),
    .xr    (xr_if.src)
  );

  blimp_result u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .xr           (xr_if.dst),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .redirect_val (redirect_val),
    .redirect_pc  (redirect_pc),
    .trace_val    (trace_val),
    .trace_pc     (trace_pc),
    .trace_waddr  (trace_waddr),
    .trace_wdata  (trace_wdata),
    .trace_wen    (trace_wen)
  );

endmodule

// ==== source/blimp_result.sv ====
/*
 * Result stage: retires one instruction per record.
 * Drives the register write, the trace and the fetch redirect from one register.
 */
module blimp_result import blimp_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  blimp_xr_if.dst               xr,
  // Register file write
  output logic                  wb_en,
  output logic [reg_addr_w-1:0] wb_addr,
  output logic [xlen-1:0]       wb_data,
  // Back to fetch
  output logic                  redirect_val,
  output logic [xlen-1:0]       redirect_pc,
  // Trace
  output logic                  trace_val,
  output logic [xlen-1:0]       trace_pc,
  output logic [reg_addr_w-1:0] trace_waddr,
  output logic [xlen-1:0]       trace_wdata,
  output logic                  trace_wen
);

  logic                  ret_val;
  logic [xlen-1:0]       ret_pc;
  logic [reg_addr_w-1:0] ret_waddr;
  logic [xlen-1:0]       ret_wdata;
  logic                  ret_wen;
  logic [xlen-1:0]       ret_next_pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ret_val <= 1'b0;
    else
      ret_val <= xr.val;
  end

  always_ff @(posedge clk) begin
    if (xr.val) begin
      ret_pc      <= xr.pc;
      ret_waddr   <= xr.waddr;
      ret_wdata   <= xr.wdata;
      ret_wen     <= xr.wen;
      ret_next_pc <= xr.next_pc;
    end
  end

  // Write lands the same cycle the trace reports it
  assign wb_en        = ret_val && ret_wen;
  assign wb_addr      = ret_waddr;
  assign wb_data      = ret_wdata;
  assign redirect_val = ret_val;
  assign redirect_pc  = ret_next_pc;

  assign trace_val   = ret_val;
  assign trace_pc    = ret_pc;
  assign trace_waddr = ret_waddr;
  assign trace_wdata = ret_wdata;
  assign trace_wen   = ret_wen;

  // One instruction in flight, so retirements are never back to back
  a_trace_gap: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |=> !trace_val);

endmodule

// ==== source/blimp_execute.sv ====
/*
 * Execute stage: ALU, branch compare and next-pc select.
 * Registers one result record for the result stage.
 */
module blimp_execute import blimp_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  blimp_dx_if.dst dx,
  blimp_xr_if.src xr
);

  logic [xlen-1:0] op_b;
  logic [xlen-1:0] link_pc;
  logic [xlen-1:0] alu_res;
  logic            taken;

  // Immediate forms share the ALU
  assign op_b    = dx.use_imm ? dx.imm : dx.rs2_data;
  assign link_pc = dx.pc + pc_step;

  always_comb begin
    case (dx.op)
      OP_ADD:  alu_res = dx.rs1_data + op_b;
      OP_SUB:  alu_res = dx.rs1_data - op_b;
      OP_AND:  alu_res = dx.rs1_data & op_b;
      OP_OR:   alu_res = dx.rs1_data | op_b;
      OP_XOR:  alu_res = dx.rs1_data ^ op_b;
      // Signed compare
      OP_SLT:  alu_res = {{(xlen-1){1'b0}}, $signed(dx.rs1_data) < $signed(op_b)};
      OP_LUI:  alu_res = dx.imm;
      OP_JAL:  alu_res = link_pc;
      default: alu_res = wdata_none;
    endcase
  end

  // Branches compare the two registers, never the immediate
  always_comb begin
    case (dx.op)
      OP_BEQ:  taken = (dx.rs1_data == dx.rs2_data);
      OP_BNE:  taken = (dx.rs1_data != dx.rs2_data);
      OP_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Stage register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      xr.val <= 1'b0;
    else
      xr.val <= dx.val;
  end

  always_ff @(posedge clk) begin
    if (dx.val) begin
      xr.pc      <= dx.pc;
      xr.waddr   <= dx.waddr;
      xr.wdata   <= alu_res;
      xr.wen     <= dx.wen;
      xr.next_pc <= taken ? dx.pc + dx.imm : link_pc;
    end
  end

endmodule

// ==== source/blimp_decode.sv ====
/*
 * Decode stage: maps the RV32 encoding to an internal opcode,
 * builds the immediate and reads the register file it owns.
 */
module blimp_decode import blimp_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // From fetch
  input  logic                  fd_val,
  input  logic [xlen-1:0]       fd_pc,
  input  logic [xlen-1:0]       fd_inst,
  // To execute
  blimp_dx_if.src               dx,
  // Register write from result
  input  logic                  wb_en,
  input  logic [reg_addr_w-1:0] wb_addr,
  input  logic [xlen-1:0]       wb_data
);

  logic [xlen-1:0]       regs [32];
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  blimp_op_e             op;
  logic                  use_imm;
  logic [xlen-1:0]       imm;
  logic                  wen;

  assign opcode = fd_inst[6:0];
  assign rd     = fd_inst[11:7];
  assign funct3 = fd_inst[14:12];
  assign rs1    = fd_inst[19:15];
  assign rs2    = fd_inst[24:20];
  assign funct7 = fd_inst[31:25];

  // ----------------------------------------------------------------------
  // Opcode and immediate
  // ----------------------------------------------------------------------

  always_comb begin
    op      = OP_ILLEGAL;
    use_imm = 1'b0;
    imm     = '0;
    case (opcode)
      opc_op: begin
        if (funct7 == f7_base) begin
          case (funct3)
            f3_add_sub: op = OP_ADD;
            f3_slt:     op = OP_SLT;
            f3_xor:     op = OP_XOR;
            f3_or:      op = OP_OR;
            f3_and:     op = OP_AND;
            default:    op = OP_ILLEGAL;
          endcase
        end else if (funct7 == f7_sub && funct3 == f3_add_sub) begin
          op = OP_SUB;
        end
      end
      // I-type, no SLTI
      opc_op_imm: begin
        use_imm = 1'b1;
        imm     = {{20{fd_inst[31]}}, fd_inst[31:20]};
        case (funct3)
          f3_add_sub: op = OP_ADD;
          f3_xor:     op = OP_XOR;
          f3_or:      op = OP_OR;
          f3_and:     op = OP_AND;
          default:    op = OP_ILLEGAL;
        endcase
      end
      // U-type
      opc_lui: begin
        op  = OP_LUI;
        imm = {fd_inst[31:12], 12'b0};
      end
      // B-type offset
      opc_branch: begin
        imm = {{19{fd_inst[31]}}, fd_inst[31], fd_inst[7], fd_inst[30:25],
               fd_inst[11:8], 1'b0};
        if (funct3 == f3_beq)
          op = OP_BEQ;
        else if (funct3 == f3_bne)
          op = OP_BNE;
      end
      // J-type offset
      opc_jal: begin
        op  = OP_JAL;
        imm = {{11{fd_inst[31]}}, fd_inst[31], fd_inst[19:12], fd_inst[20],
               fd_inst[30:21], 1'b0};
      end
      default: op = OP_ILLEGAL;
    endcase
  end

  // No write for x0, branches or illegal words
  assign wen = (rd != reg_zero) && !(op inside {OP_BEQ, OP_BNE, OP_ILLEGAL});

  // ----------------------------------------------------------------------
  // Register file and stage register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wb_en)
      regs[wb_addr] <= wb_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      dx.val <= 1'b0;
    else
      dx.val <= fd_val;
  end

  always_ff @(posedge clk) begin
    if (fd_val) begin
      dx.pc       <= fd_pc;
      dx.op       <= op;
      dx.use_imm  <= use_imm;
      // x0 reads zero
      dx.rs1_data <= (rs1 == reg_zero) ? '0 : regs[rs1];
      dx.rs2_data <= (rs2 == reg_zero) ? '0 : regs[rs2];
      dx.imm      <= imm;
      dx.waddr    <= rd;
      dx.wen      <= wen;
    end
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wb_en |-> wb_addr != reg_zero);

endmodule

// ==== source/blimp_fetch.sv ====
/*
 * Fetch stage: pc register and instruction-memory request FSM.
 * Issues one request, forwards the response, then waits for the redirect.
 */
module blimp_fetch import blimp_pkg::*; #(
  parameter logic [xlen-1:0] p_reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst_n,
  // Instruction memory
  output logic            imem_req_val,
  output logic [xlen-1:0] imem_req_addr,
  input  logic            imem_req_rdy,
  input  logic            imem_resp_val,
  input  logic [xlen-1:0] imem_resp_data,
  // To decode
  output logic            fd_val,
  output logic [xlen-1:0] fd_pc,
  output logic [xlen-1:0] fd_inst,
  // From result
  input  logic            redirect_val,
  input  logic [xlen-1:0] redirect_pc
);

  fetch_state_e    state;
  fetch_state_e    state_next;
  logic [xlen-1:0] pc;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // Hold address until the memory takes it
      F_REQ:
        if (imem_req_val && imem_req_rdy)
          state_next = F_WAIT;
      F_WAIT:
        if (imem_resp_val)
          state_next = F_HOLD;
      // Instruction in flight, wait for retirement
      F_HOLD:
        if (redirect_val)
          state_next = F_REQ;
      default:
        state_next = F_REQ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= F_REQ;
      pc    <= p_reset_pc;
    end else begin
      state <= state_next;
      if (state == F_HOLD && redirect_val)
        pc <= redirect_pc;
    end
  end

  assign imem_req_val  = (state == F_REQ);
  assign imem_req_addr = pc;

  // Response goes straight through to decode
  assign fd_val  = (state == F_WAIT) && imem_resp_val;
  assign fd_pc   = pc;
  assign fd_inst = imem_resp_data;

  // Address must not move under back-pressure
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_val && !imem_req_rdy |=> imem_req_val && $stable(imem_req_addr));

  // Memory answers only an accepted request
  a_resp_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    imem_resp_val |-> state == F_WAIT);

endmodule

// ==== source/blimp_stage_if.sv ====
/*
 * Stage-to-stage links inside the core.
 * Decode feeds execute, execute feeds result; each has a src and dst side.
 */

// Decoded instruction with operands read
interface blimp_dx_if import blimp_pkg::*; ();
  logic                  val;
  logic [xlen-1:0]       pc;
  blimp_op_e             op;
  logic                  use_imm;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       imm;
  logic [reg_addr_w-1:0] waddr;
  logic                  wen;

  modport src (output val, pc, op, use_imm, rs1_data, rs2_data, imm, waddr, wen);
  modport dst (input  val, pc, op, use_imm, rs1_data, rs2_data, imm, waddr, wen);
endinterface

// Executed instruction, ready to retire
interface blimp_xr_if import blimp_pkg::*; ();
  logic                  val;
  logic [xlen-1:0]       pc;
  logic [reg_addr_w-1:0] waddr;
  logic [xlen-1:0]       wdata;
  logic                  wen;
  logic [xlen-1:0]       next_pc;

  modport src (output val, pc, waddr, wdata, wen, next_pc);
  modport dst (input  val, pc, waddr, wdata, wen, next_pc);
endinterface

// ==== source/blimp_pkg.sv ====
/*
 * Shared types and constants for the blimp core.
 * Imported by every RTL module and by the testbench checker.
 */
package blimp_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // ----------------------------------------------------------------------
  // Internal opcodes
  // ----------------------------------------------------------------------

  // Immediate forms reuse the ALU codes, use_imm selects the operand
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_JAL,
    OP_ILLEGAL
  } blimp_op_e;

  // ----------------------------------------------------------------------
  // RV32 encoding fields
  // ----------------------------------------------------------------------

  // Major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;

  // funct3, shared by register and immediate ALU forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  // funct3 for branches
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;

  // funct7
  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_sub     = 7'b0100000;

  // ----------------------------------------------------------------------
  // Writeback and trace
  // ----------------------------------------------------------------------

  localparam logic [xlen-1:0]       pc_step    = 32'd4;
  localparam logic [reg_addr_w-1:0] reg_zero   = '0;
  // Data reported for instructions that write nothing
  localparam logic [xlen-1:0]       wdata_none = '0;

  // Fetch FSM
  typedef enum logic [1:0] {
    F_REQ,
    F_WAIT,
    F_HOLD
  } fetch_state_e;

endpackage
